//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int XLEN       = 32;
  localparam int PADDR_W    = 20;
  localparam int PPN_W      = 8;
  localparam int PAGE_OFS_W = 12;
  localparam int LINE_WORDS = 4;

  localparam int DEF_TLB_ENTRIES = 4;
  localparam int DEF_CACHE_LINES = 16;

  typedef logic [XLEN-1:0]            vaddr_t;
  typedef logic [PADDR_W-1:0]         paddr_t;
  typedef logic [PPN_W-1:0]           ppn_t;
  typedef logic [XLEN-PAGE_OFS_W-1:0] vpn_t;
  typedef logic [XLEN-1:0]            instruction_t;
  typedef logic [LINE_WORDS*XLEN-1:0] cacheline_t;

  // RISC-V mcause encoding
  typedef enum logic [3:0] {
    EXC_NONE         = 4'd0,
    INSTR_PAGE_FAULT = 4'd12
  } excpt_cause_t;

  typedef struct packed {
    vaddr_t       pc;
    instruction_t instr;
    logic         excpt;
    excpt_cause_t cause;
  } dec_pkt_t;

  // Always line aligned
  typedef struct packed {
    paddr_t addr;
  } mem_req_t;

  localparam vaddr_t RESET_PC = 32'h0000_1000;

endpackage

`default_nettype wire

//--- logic/itlb.sv
`default_nettype none

module itlb #(
  parameter int ENTRIES = fetch_pkg::DEF_TLB_ENTRIES
) (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire                  flush_i,
  input  wire                  wr_en_i,
  input  wire fetch_pkg::vpn_t vpn_i,
  input  wire fetch_pkg::ppn_t ppn_i,
  output logic                 hit_o,
  output fetch_pkg::ppn_t      ppn_o
);
  import fetch_pkg::*;

  localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  vpn_t               tag_q [ENTRIES];
  ppn_t               ppn_q [ENTRIES];
  logic [ENTRIES-1:0] valid_q;
  logic [ENTRIES-1:0] match;
  logic [PTR_W-1:0]   victim_q;

  // Parallel tag compare
  always_comb begin
    ppn_o = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      match[i] = valid_q[i] && (tag_q[i] == vpn_i);
      if (match[i]) begin
        ppn_o = ppn_o | ppn_q[i];
      end
    end
  end

  assign hit_o = |match;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[victim_q] <= 1'b1;
      // Round robin over all entries
      if (victim_q == PTR_W'(ENTRIES - 1)) begin
        victim_q <= '0;
      end else begin
        victim_q <= victim_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i && !flush_i) begin
      tag_q[victim_q] <= vpn_i;
      ppn_q[victim_q] <= ppn_i;
    end
  end

  // Fetch only fills on a miss, so a page never lands twice
  a_single_match: assert property (@(posedge clk_i) disable iff (!rst_i)
    $onehot0(match));

endmodule

`default_nettype wire

//--- logic/iptw.sv
`default_nettype none

module iptw (
  input  wire                    req_i,
  input  wire fetch_pkg::vaddr_t vaddr_i,
  input  wire fetch_pkg::ppn_t   satp_ppn_i,
  input  wire                    present_i,
  output logic                   present_req_o,
  output fetch_pkg::ppn_t        present_ppn_o,
  output logic                   fault_o,
  output fetch_pkg::paddr_t      paddr_o
);
  import fetch_pkg::*;

  vpn_t vpn;
  ppn_t ppn;

  assign vpn = vaddr_i[XLEN-1:PAGE_OFS_W];

  // Single level table, page number wraps at 8 bits
  assign ppn = satp_ppn_i + vpn[PPN_W-1:0];

  assign present_req_o = req_i;
  assign present_ppn_o = req_i ? ppn : '0;

  // Present table answers in the same cycle
  assign fault_o = req_i && !present_i;
  assign paddr_o = {ppn, vaddr_i[PAGE_OFS_W-1:0]};

endmodule

`default_nettype wire

//--- logic/instr_cache.sv
`default_nettype none

module instr_cache #(
  parameter int LINES = fetch_pkg::DEF_CACHE_LINES
) (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire                        req_i,
  input  wire fetch_pkg::paddr_t     addr_i,
  input  wire                        abort_i,
  output logic                       rvalid_o,
  output fetch_pkg::instruction_t    rdata_o,
  output logic                       mem_req_valid_o,
  input  wire                        mem_req_ready_i,
  output fetch_pkg::mem_req_t        mem_req_o,
  input  wire                        mem_rsp_valid_i,
  input  wire fetch_pkg::cacheline_t mem_rsp_line_i
);
  import fetch_pkg::*;

  localparam int WORD_W = $clog2(LINE_WORDS);
  localparam int OFS_W  = WORD_W + 2;
  localparam int IDX_W  = $clog2(LINES);
  localparam int TAG_W  = PADDR_W - OFS_W - IDX_W;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;

  typedef enum logic [1:0] {
    READY,
    REQUEST,
    REFILL
  } state_t;

  state_t             state_q, state_d;
  tag_t               tag_q [LINES];
  cacheline_t         line_q [LINES];
  logic [LINES-1:0]   valid_q;
  paddr_t             miss_addr_q;
  logic               aborted_q;

  paddr_t             cur_addr;
  idx_t               cur_idx;
  tag_t               cur_tag;
  logic [WORD_W-1:0]  cur_word;
  logic               hit;
  logic               fill;

  // Lookup uses the live address when idle, the missed one while refilling
  assign cur_addr = (state_q == READY) ? addr_i : miss_addr_q;
  assign cur_word = cur_addr[OFS_W-1:2];
  assign cur_idx  = cur_addr[OFS_W +: IDX_W];
  assign cur_tag  = cur_addr[PADDR_W-1 -: TAG_W];
  assign hit      = valid_q[cur_idx] && (tag_q[cur_idx] == cur_tag);
  assign fill     = (state_q == REFILL) && mem_rsp_valid_i;

  assign mem_req_o = '{addr: {miss_addr_q[PADDR_W-1:OFS_W], {OFS_W{1'b0}}}};

  always_comb begin
    state_d         = state_q;
    rvalid_o        = 1'b0;
    rdata_o         = line_q[cur_idx][cur_word*XLEN +: XLEN];
    mem_req_valid_o = 1'b0;
    case (state_q)
      READY: begin
        if (req_i) begin
          if (hit) begin
            rvalid_o = 1'b1;
          end else begin
            state_d = REQUEST;
          end
        end
      end
      REQUEST: begin
        mem_req_valid_o = 1'b1;
        if (mem_req_ready_i) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (mem_rsp_valid_i) begin
          // Forward the word straight from the returning line
          rdata_o  = mem_rsp_line_i[cur_word*XLEN +: XLEN];
          rvalid_o = !aborted_q && !abort_i;
          state_d  = READY;
        end
      end
      default: state_d = READY;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q   <= READY;
      valid_q   <= '0;
      aborted_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fill) begin
        valid_q[cur_idx] <= 1'b1;
      end
      if (state_q == READY) begin
        aborted_q <= 1'b0;
      end else if (abort_i) begin
        aborted_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == READY) && req_i && !hit) begin
      miss_addr_q <= addr_i;
    end
    if (fill) begin
      tag_q[cur_idx]  <= cur_tag;
      line_q[cur_idx] <= mem_rsp_line_i;
    end
  end

  // One refill in flight, next request only after its response
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_valid_o && mem_req_ready_i |=> !mem_req_valid_o until_with mem_rsp_valid_i);

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`default_nettype none

module fetch_stage (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          mmu_en_i,
  input  wire                          redirect_i,
  input  wire fetch_pkg::vaddr_t       redirect_pc_i,
  input  wire                          tlb_hit_i,
  input  wire fetch_pkg::ppn_t         tlb_ppn_i,
  output logic                         tlb_wr_o,
  output fetch_pkg::vpn_t              tlb_vpn_o,
  output logic                         walk_req_o,
  input  wire                          walk_fault_i,
  input  wire fetch_pkg::paddr_t       walk_paddr_i,
  output logic                         cache_req_o,
  output fetch_pkg::paddr_t            cache_addr_o,
  output logic                         cache_abort_o,
  input  wire                          cache_rvalid_i,
  input  wire fetch_pkg::instruction_t cache_rdata_i,
  output logic                         dec_valid_o,
  input  wire                          dec_ready_i,
  output fetch_pkg::dec_pkt_t          dec_pkt_o
);
  import fetch_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT,
    DRAIN,
    HOLD
  } state_t;

  state_t   state_q, state_d;
  vaddr_t   pc_q, pc_d;
  paddr_t   xlate_paddr;
  paddr_t   paddr_q;
  dec_pkt_t live_pkt;
  dec_pkt_t buf_q;
  logic     buf_wr;
  logic     fault;

  assign tlb_vpn_o     = pc_q[XLEN-1:PAGE_OFS_W];
  assign cache_abort_o = redirect_i;

  // Address comes from the PC with the MMU off, else the TLB or a fresh walk
  always_comb begin
    walk_req_o = 1'b0;
    if (!mmu_en_i) begin
      xlate_paddr = pc_q[PADDR_W-1:0];
    end else if (tlb_hit_i) begin
      xlate_paddr = {tlb_ppn_i, pc_q[PAGE_OFS_W-1:0]};
    end else begin
      walk_req_o  = (state_q == FETCH);
      // Walker only supplies the page
      xlate_paddr = {walk_paddr_i[PADDR_W-1:PAGE_OFS_W], pc_q[PAGE_OFS_W-1:0]};
    end
  end

  assign fault    = walk_req_o && walk_fault_i;
  assign tlb_wr_o = walk_req_o && !walk_fault_i && !redirect_i;

  // WAIT keeps the address captured in FETCH
  assign cache_addr_o = (state_q == FETCH) ? xlate_paddr : paddr_q;

  always_comb begin
    live_pkt.pc = pc_q;
    if (fault) begin
      live_pkt.instr = '0;
      live_pkt.excpt = 1'b1;
      live_pkt.cause = INSTR_PAGE_FAULT;
    end else begin
      live_pkt.instr = cache_rdata_i;
      live_pkt.excpt = 1'b0;
      live_pkt.cause = EXC_NONE;
    end
  end

  assign dec_pkt_o = ((state_q == DRAIN) || (state_q == HOLD)) ? buf_q : live_pkt;

  always_comb begin
    state_d     = state_q;
    pc_d        = pc_q;
    cache_req_o = 1'b0;
    dec_valid_o = 1'b0;
    buf_wr      = 1'b0;
    case (state_q)
      IDLE: begin
        state_d = FETCH;
      end
      FETCH, WAIT: begin
        if (fault) begin
          // Fault is held until a redirect clears it
          dec_valid_o = 1'b1;
          buf_wr      = 1'b1;
          state_d     = HOLD;
        end else begin
          cache_req_o = 1'b1;
          if (cache_rvalid_i) begin
            dec_valid_o = 1'b1;
            if (dec_ready_i) begin
              pc_d    = pc_q + 32'd4;
              state_d = FETCH;
            end else begin
              buf_wr  = 1'b1;
              state_d = DRAIN;
            end
          end else begin
            state_d = WAIT;
          end
        end
      end
      DRAIN: begin
        dec_valid_o = 1'b1;
        if (dec_ready_i) begin
          pc_d    = pc_q + 32'd4;
          state_d = FETCH;
        end
      end
      HOLD: begin
        dec_valid_o = 1'b1;
      end
      default: state_d = IDLE;
    endcase

    // Redirect drops whatever is pending
    if (redirect_i) begin
      cache_req_o = 1'b0;
      pc_d        = redirect_pc_i;
      state_d     = FETCH;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= IDLE;
      pc_q    <= RESET_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_wr) begin
      buf_q <= live_pkt;
    end
    if (state_q == FETCH) begin
      paddr_q <= xlate_paddr;
    end
  end

  // Stall buffer keeps an offered packet intact until decode takes it
  a_pkt_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
    dec_valid_o && !dec_ready_i && !redirect_i |=> dec_valid_o && $stable(dec_pkt_o));

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`default_nettype none

module fetch_unit #(
  parameter int TLB_ENTRIES = fetch_pkg::DEF_TLB_ENTRIES,
  parameter int CACHE_LINES = fetch_pkg::DEF_CACHE_LINES
) (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire                        vm_en_i,
  input  wire                        trap_bypass_mmu_i,
  input  wire fetch_pkg::ppn_t       satp_ppn_i,
  input  wire                        flush_i,
  input  wire fetch_pkg::vaddr_t     flush_pc_i,
  input  wire                        branch_taken_i,
  input  wire fetch_pkg::vaddr_t     branch_pc_i,
  input  wire                        jump_i,
  input  wire fetch_pkg::vaddr_t     jump_pc_i,
  input  wire                        present_i,
  output logic                       present_req_o,
  output fetch_pkg::ppn_t            present_ppn_o,
  output logic                       mem_req_valid_o,
  input  wire                        mem_req_ready_i,
  output fetch_pkg::mem_req_t        mem_req_o,
  input  wire                        mem_rsp_valid_i,
  input  wire fetch_pkg::cacheline_t mem_rsp_line_i,
  output logic                       dec_valid_o,
  input  wire                        dec_ready_i,
  output fetch_pkg::dec_pkt_t        dec_pkt_o
);
  import fetch_pkg::*;

  logic         mmu_en;
  logic         redirect;
  vaddr_t       redirect_pc;
  logic         tlb_hit;
  ppn_t         tlb_ppn;
  logic         tlb_wr;
  vpn_t         tlb_vpn;
  logic         walk_req;
  logic         walk_fault;
  paddr_t       walk_paddr;
  logic         cache_req;
  paddr_t       cache_addr;
  logic         cache_abort;
  logic         cache_rvalid;
  instruction_t cache_rdata;

  assign mmu_en   = vm_en_i && !trap_bypass_mmu_i;
  assign redirect = flush_i || branch_taken_i || jump_i;

  // Flush beats branch, branch beats jump
  assign redirect_pc = flush_i        ? flush_pc_i  :
                       branch_taken_i ? branch_pc_i : jump_pc_i;

  fetch_stage u_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .mmu_en_i       (mmu_en),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .tlb_hit_i      (tlb_hit),
    .tlb_ppn_i      (tlb_ppn),
    .tlb_wr_o       (tlb_wr),
    .tlb_vpn_o      (tlb_vpn),
    .walk_req_o     (walk_req),
    .walk_fault_i   (walk_fault),
    .walk_paddr_i   (walk_paddr),
    .cache_req_o    (cache_req),
    .cache_addr_o   (cache_addr),
    .cache_abort_o  (cache_abort),
    .cache_rvalid_i (cache_rvalid),
    .cache_rdata_i  (cache_rdata),
    .dec_valid_o    (dec_valid_o),
    .dec_ready_i    (dec_ready_i),
    .dec_pkt_o      (dec_pkt_o)
  );

  itlb #(
    .ENTRIES (TLB_ENTRIES)
  ) u_itlb (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .wr_en_i (tlb_wr),
    .vpn_i   (tlb_vpn),
    .ppn_i   (walk_paddr[PADDR_W-1:PAGE_OFS_W]),
    .hit_o   (tlb_hit),
    .ppn_o   (tlb_ppn)
  );

  iptw u_iptw (
    .req_i         (walk_req),
    .vaddr_i       ({tlb_vpn, {PAGE_OFS_W{1'b0}}}),
    .satp_ppn_i    (satp_ppn_i),
    .present_i     (present_i),
    .present_req_o (present_req_o),
    .present_ppn_o (present_ppn_o),
    .fault_o       (walk_fault),
    .paddr_o       (walk_paddr)
  );

  instr_cache #(
    .LINES (CACHE_LINES)
  ) u_cache (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_i           (cache_req),
    .addr_i          (cache_addr),
    .abort_i         (cache_abort),
    .rvalid_o        (cache_rvalid),
    .rdata_o         (cache_rdata),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_line_i  (mem_rsp_line_i)
  );

endmodule

`default_nettype wire

//--- tests/fetch_mem_model.sv
`default_nettype none

module fetch_mem_model #(
  parameter logic [31:0] DATA_KEY  = 32'h0,
  parameter logic [7:0]  FAULT_PPN = 8'h0
) (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire                        req_valid_i,
  output logic                       req_ready_o,
  input  wire fetch_pkg::mem_req_t   req_i,
  output logic                       rsp_valid_o,
  output fetch_pkg::cacheline_t      rsp_line_o,
  input  wire                        present_req_i,
  input  wire fetch_pkg::ppn_t       present_ppn_i,
  output logic                       present_o
);
  import fetch_pkg::*;

  integer seed;
  logic   busy;
  paddr_t line_addr;
  int     accept_cnt;
  int     rsp_cnt;

  // Page walk answer comes back in the same cycle
  assign present_o = !(present_req_i && (present_ppn_i == FAULT_PPN));

  function automatic cacheline_t build_line(input paddr_t base);
    cacheline_t line;
    for (int i = 0; i < 4; i++) begin
      line[i*32 +: 32] = {12'h0, base + paddr_t'(4 * i)} ^ DATA_KEY;
    end
    return line;
  endfunction

  initial begin
    seed        = 32'hafdd;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_line_o  = '0;
  end

  always @(negedge clk_i) begin
    if (!rst_i) begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_line_o  <= '0;
      busy        <= 1'b0;
      accept_cnt  <= $unsigned($random(seed)) % 4;
      rsp_cnt     <= 0;
    end else begin
      rsp_valid_o <= 1'b0;
      if (busy) begin
        if (rsp_cnt == 0) begin
          rsp_valid_o <= 1'b1;
          rsp_line_o  <= build_line(line_addr);
          busy        <= 1'b0;
          accept_cnt  <= $unsigned($random(seed)) % 4;
        end else begin
          rsp_cnt <= rsp_cnt - 1;
        end
      end else if (req_ready_o) begin
        // Handshake happened on the last rising edge
        req_ready_o <= 1'b0;
        line_addr   <= req_i.addr;
        busy        <= 1'b1;
        rsp_cnt     <= 1 + $unsigned($random(seed)) % 4;
      end else if (req_valid_i) begin
        if (accept_cnt == 0) begin
          req_ready_o <= 1'b1;
        end else begin
          accept_cnt <= accept_cnt - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_fetch_unit.sv
`default_nettype none

module tb_fetch_unit;
  import fetch_pkg::*;

  localparam logic [31:0] DATA_KEY  = 32'h1357_9BDF;
  localparam logic [7:0]  FAULT_PPN = 8'h45;
  localparam int          TIMEOUT   = 300;

  // Redirect kind 0 is none, 1 flush, 2 branch, 3 jump and 4 flush with branch
  typedef struct packed {
    logic        vm_en;
    logic        bypass;
    logic [7:0]  satp;
    logic [2:0]  kind;
    logic [31:0] target;
    logic [7:0]  npkts;
    logic [7:0]  ready_pct;
    logic        no_refetch;
  } row_t;

  logic       clk_i;
  logic       rst_i;
  logic       vm_en_i;
  logic       trap_bypass_mmu_i;
  ppn_t       satp_ppn_i;
  logic       flush_i;
  vaddr_t     flush_pc_i;
  logic       branch_taken_i;
  vaddr_t     branch_pc_i;
  logic       jump_i;
  vaddr_t     jump_pc_i;
  logic       present_i;
  logic       present_req_o;
  ppn_t       present_ppn_o;
  logic       mem_req_valid_o;
  logic       mem_req_ready_i;
  mem_req_t   mem_req_o;
  logic       mem_rsp_valid_i;
  cacheline_t mem_rsp_line_i;
  logic       dec_valid_o;
  logic       dec_ready_i;
  dec_pkt_t   dec_pkt_o;

  row_t   rows [$];
  integer seed;
  int     error_count;
  int     refetch_reqs;

  fetch_unit u_dut (.*);

  fetch_mem_model #(
    .DATA_KEY  (DATA_KEY),
    .FAULT_PPN (FAULT_PPN)
  ) u_mem (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (mem_req_valid_o),
    .req_ready_o   (mem_req_ready_i),
    .req_i         (mem_req_o),
    .rsp_valid_o   (mem_rsp_valid_i),
    .rsp_line_o    (mem_rsp_line_i),
    .present_req_i (present_req_o),
    .present_ppn_i (present_ppn_o),
    .present_o     (present_i)
  );

  always #20 clk_i = ~clk_i;

  task automatic stop_with_error(input string what);
    error_count++;
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                                $time, name, got, exp));
    end
  endtask

  task automatic add_row(input logic vm, input logic byp, input logic [7:0] satp,
                         input logic [2:0] kind, input logic [31:0] target,
                         input int npkts, input int pct, input logic no_refetch);
    row_t r;
    r = '{vm, byp, satp, kind, target, npkts[7:0], pct[7:0], no_refetch};
    rows.push_back(r);
  endtask

  task automatic apply_redirect(input row_t r);
    @(negedge clk_i);
    vm_en_i           = r.vm_en;
    trap_bypass_mmu_i = r.bypass;
    satp_ppn_i        = r.satp;
    dec_ready_i       = 1'b0;
    case (r.kind)
      3'd1: begin
        flush_i    = 1'b1;
        flush_pc_i = r.target;
      end
      3'd2: begin
        branch_taken_i = 1'b1;
        branch_pc_i    = r.target;
      end
      3'd3: begin
        jump_i    = 1'b1;
        jump_pc_i = r.target;
      end
      3'd4: begin
        flush_i        = 1'b1;
        flush_pc_i     = r.target;
        branch_taken_i = 1'b1;
        branch_pc_i    = r.target ^ 32'h200;
      end
      default: ;
    endcase
  endtask

  // Expected packet from the translation and memory rules
  task automatic check_packet(input row_t r, input vaddr_t pc, output logic fault);
    logic [7:0]  ppn;
    logic [19:0] paddr;
    ppn   = r.satp + pc[19:12];
    fault = r.vm_en && !r.bypass && (ppn == FAULT_PPN);
    paddr = (r.vm_en && !r.bypass) ? {ppn, pc[11:0]} : pc[19:0];
    compare("dec_pkt_o.pc", 64'(dec_pkt_o.pc), 64'(pc));
    compare("dec_pkt_o.excpt", 64'(dec_pkt_o.excpt), 64'(fault));
    compare("dec_pkt_o.cause", 64'(dec_pkt_o.cause),
            64'(fault ? INSTR_PAGE_FAULT : EXC_NONE));
    if (!fault) begin
      compare("dec_pkt_o.instr", 64'(dec_pkt_o.instr), 64'({12'h0, paddr} ^ DATA_KEY));
    end
  endtask

  task automatic run_row(input int idx, input row_t r);
    vaddr_t pc;
    int     got;
    int     idle;
    logic   fault;
    logic [19:0] lo;
    logic [19:0] hi;
    pc           = r.target;
    got          = 0;
    idle         = 0;
    refetch_reqs = 0;
    lo           = {r.target[19:4], 4'h0};
    hi           = r.target[19:0] + 20'(r.npkts * 4);
    while (got < r.npkts) begin
      @(negedge clk_i);
      flush_i        = 1'b0;
      branch_taken_i = 1'b0;
      jump_i         = 1'b0;
      dec_ready_i    = ($unsigned($random(seed)) % 100) < r.ready_pct;
      #10;
      if (mem_req_valid_o && mem_req_ready_i &&
          mem_req_o.addr >= lo && mem_req_o.addr < hi) begin
        refetch_reqs++;
      end
      if (dec_valid_o && dec_ready_i) begin
        check_packet(r, pc, fault);
        if (!fault) begin
          pc = pc + 32'd4;
        end
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          stop_with_error($sformatf("Timeout in row %0d, decode saw no packet for %0d cycles",
                                    idx, TIMEOUT));
        end
      end
    end
    if (r.no_refetch) begin
      compare("mem_req_valid_o count", 64'(refetch_reqs), 64'd0);
    end
  endtask

  initial begin
    seed              = 32'hafdd;
    error_count       = 0;
    clk_i             = 1'b0;
    rst_i             = 1'b0;
    vm_en_i           = 1'b0;
    trap_bypass_mmu_i = 1'b0;
    satp_ppn_i        = '0;
    flush_i           = 1'b0;
    flush_pc_i        = '0;
    branch_taken_i    = 1'b0;
    branch_pc_i       = '0;
    jump_i            = 1'b0;
    jump_pc_i         = '0;
    dec_ready_i       = 1'b0;

    add_row(1'b0, 1'b0, 8'h00, 3'd0, RESET_PC,      12, 100, 1'b0);
    add_row(1'b0, 1'b0, 8'h00, 3'd2, RESET_PC,      12,  50, 1'b1);
    add_row(1'b0, 1'b0, 8'h00, 3'd3, 32'h0000_2344, 10,  70, 1'b0);
    add_row(1'b1, 1'b0, 8'h30, 3'd4, 32'h0000_3000, 20,  60, 1'b0);
    add_row(1'b1, 1'b0, 8'h30, 3'd3, 32'h0000_3FF0,  8,  80, 1'b0);
    add_row(1'b1, 1'b0, 8'h30, 3'd2, 32'h0001_5000,  3,  50, 1'b0);
    add_row(1'b1, 1'b1, 8'h30, 3'd1, 32'h0000_5100,  8, 100, 1'b0);
    add_row(1'b1, 1'b0, 8'h30, 3'd1, 32'h0000_6008,  6,  40, 1'b0);

    repeat (10) @(negedge clk_i);
    rst_i = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].kind != 3'd0) begin
        apply_redirect(rows[i]);
      end
      run_row(i, rows[i]);
    end

    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_unit.f
logic/fetch_pkg.sv
logic/itlb.sv
logic/iptw.sv
logic/instr_cache.sv
logic/fetch_stage.sv
logic/fetch_unit.sv
tests/fetch_mem_model.sv
tests/tb_fetch_unit.sv
